// ==== common/spi_regs_pkg.sv ====
package spi_regs_pkg;

  // frame geometry, MSB first on the wire
  localparam int FRAME_BITS = 32;
  localparam int CMD_BITS   = 8;  // opcode + address
  localparam int DATA_BITS  = 24; // payload and register width
  localparam int ADDR_BITS  = 6;

  // bit counter saturates one past a full frame so long frames are caught
  localparam int CNT_MAX  = FRAME_BITS + 1;
  localparam int CNT_BITS = $clog2(CNT_MAX + 1);

  // register map
  localparam logic [ADDR_BITS-1:0] REG_LED     = 6'd7;
  localparam logic [ADDR_BITS-1:0] REG_SPI_MUX = 6'd8;
  localparam logic [ADDR_BITS-1:0] REG_4094    = 6'd9;

  // readback for anything outside the map
  localparam logic [DATA_BITS-1:0] UNMAPPED_VALUE = 24'd12345;

  // alternating pattern, handy to spot stuck LED lines at power up
  localparam logic [DATA_BITS-1:0] LED_RESET_VALUE = 24'hAA_AAAA;

  // command bits 7:6
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_SET   = 2'd2, // or data into register
    OP_CLEAR = 2'd3  // clear bits set in data
  } spi_op_e;

  // wire order, first bit received ends up in op[1]
  typedef struct packed {
    spi_op_e               op;
    logic [ADDR_BITS-1:0]  addr;
    logic [DATA_BITS-1:0]  data;
  } spi_frame_t;

  // the register bank as seen from the board
  typedef struct packed {
    logic [DATA_BITS-1:0] led;
    logic [DATA_BITS-1:0] spi_mux; // selects the active downstream spi device
    logic [DATA_BITS-1:0] sr_4094; // 4094 shift register state
  } reg_file_t;

endpackage

// ==== logic/pin_sync.sv ====
module pin_sync (
  input  logic cs,
  input  logic rst,
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  output logic mosi_s,
  output logic ss_active,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic ss_fall,
  output logic ss_rise
);

  logic [1:0] sclk_sync;
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  logic       sclk_prev; // last synchronized level, for edges
  logic       ss_prev;

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sclk_sync <= 2'b00;
      ss_sync   <= 2'b11; // deselected while in reset
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
      ss_prev   <= 1'b1;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      ss_fall   <= 1'b0;
      ss_rise   <= 1'b0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      ss_sync   <= {ss_sync[0], ss_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
      ss_prev   <= ss_sync[1];
      // registered edge pulses, third stage after the pin
      sclk_rise <= sclk_sync[1] & ~sclk_prev;
      sclk_fall <= ~sclk_sync[1] & sclk_prev;
      ss_fall   <= ~ss_sync[1] & ss_prev;
      ss_rise   <= ss_sync[1] & ~ss_prev;
    end
  end

  assign mosi_s    = mosi_sync[1];
  assign ss_active = ~ss_sync[1]; // active low select
endmodule

// ==== spi_slave/spi_frame_shifter.sv ====
module spi_frame_shifter (
  input  logic                                   cs,
  input  logic                                   rst,
  input  logic                                   mosi_s,
  input  logic                                   ss_active,
  input  logic                                   sclk_rise,
  input  logic                                   sclk_fall,
  input  logic                                   ss_fall,
  input  logic                                   ss_rise,
  input  logic [spi_regs_pkg::DATA_BITS-1:0]     rd_data,
  output logic                                   miso,
  output logic [spi_regs_pkg::ADDR_BITS-1:0]     rd_addr,
  output logic                                   addr_strobe,
  output spi_regs_pkg::spi_frame_t               frame,
  output logic                                   frame_done
);

  localparam logic [spi_regs_pkg::CNT_BITS-1:0] CNT_SAT =
    spi_regs_pkg::CNT_BITS'(spi_regs_pkg::CNT_MAX);
  localparam logic [spi_regs_pkg::CNT_BITS-1:0] CNT_CMD_LAST =
    spi_regs_pkg::CNT_BITS'(spi_regs_pkg::CMD_BITS - 1);
  localparam logic [spi_regs_pkg::CNT_BITS-1:0] CNT_FULL =
    spi_regs_pkg::CNT_BITS'(spi_regs_pkg::FRAME_BITS);

  logic [spi_regs_pkg::FRAME_BITS-1:0] in_sh;  // mosi shift register
  logic [spi_regs_pkg::DATA_BITS-1:0]  out_sh; // readback shift register
  logic [spi_regs_pkg::CNT_BITS-1:0]   cnt;    // rises seen this frame

  // incoming payload, cleared at frame start so stale bits never leak in
  always_ff @(posedge cs)
  begin
    if (ss_fall)
      in_sh <= '0;
    else if (ss_active && sclk_rise)
      in_sh <= {in_sh[spi_regs_pkg::FRAME_BITS-2:0], mosi_s}; // msb first
  end

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      cnt         <= '0;
      out_sh      <= '0;
      miso        <= 1'b0;
      addr_strobe <= 1'b0;
    end
    else
    begin
      addr_strobe <= 1'b0; // single cycle pulse
      if (ss_fall)
      begin
        cnt    <= '0;
        out_sh <= '0; // command byte reads back as zeros
        miso   <= 1'b0;
      end
      else if (ss_active)
      begin
        if (sclk_rise)
        begin
          if (cnt != CNT_SAT)
            cnt <= cnt + 1'b1; // saturate, long frames stay long
          // 8th bit lands this cycle, address valid next cycle
          if (cnt == CNT_CMD_LAST)
            addr_strobe <= 1'b1;
        end
        if (addr_strobe)
          out_sh <= rd_data; // bank answers combinationally
        else if (sclk_fall)
        begin
          miso   <= out_sh[spi_regs_pkg::DATA_BITS-1];
          out_sh <= {out_sh[spi_regs_pkg::DATA_BITS-2:0], 1'b0};
        end
      end
    end
  end

  // address is the low bits of the command byte once 8 bits are in
  assign rd_addr = in_sh[spi_regs_pkg::ADDR_BITS-1:0];
  assign frame   = spi_regs_pkg::spi_frame_t'(in_sh);

  // only an exact 32 bit frame gets applied
  assign frame_done = ss_rise && (cnt == CNT_FULL);

  // ss_rise is a pin event several cycles after the last rise, never near the
  // command byte
  a_done_not_strobe : assert property (@(posedge cs) disable iff (rst)
    !(frame_done && addr_strobe));

  a_cnt_bound : assert property (@(posedge cs) disable iff (rst)
    cnt <= CNT_SAT);
endmodule

// ==== spi_slave/reg_bank.sv ====
module reg_bank (
  input  logic                               cs,
  input  logic                               rst,
  input  logic [spi_regs_pkg::ADDR_BITS-1:0] rd_addr,
  output logic [spi_regs_pkg::DATA_BITS-1:0] rd_data,
  input  logic                               frame_done,
  input  spi_regs_pkg::spi_frame_t           frame,
  output spi_regs_pkg::reg_file_t            regs
);

  logic       wr_any;  // frame modifies something
  logic [2:0] wr_en;   // led, spi_mux, sr_4094

  // next register value for a given opcode
  function automatic logic [spi_regs_pkg::DATA_BITS-1:0] apply_op(
    input logic [spi_regs_pkg::DATA_BITS-1:0] cur,
    input spi_regs_pkg::spi_op_e              op,
    input logic [spi_regs_pkg::DATA_BITS-1:0] data
  );
    logic [spi_regs_pkg::DATA_BITS-1:0] nxt;
    case (op)
      spi_regs_pkg::OP_WRITE: nxt = data;
      spi_regs_pkg::OP_SET:   nxt = cur | data;
      spi_regs_pkg::OP_CLEAR: nxt = cur & ~data;
      default:                nxt = cur; // read leaves it alone
    endcase
    return nxt;
  endfunction

  // readback mux, every frame gets this regardless of opcode
  always_comb
  begin
    case (rd_addr)
      spi_regs_pkg::REG_LED:     rd_data = regs.led;
      spi_regs_pkg::REG_SPI_MUX: rd_data = regs.spi_mux;
      spi_regs_pkg::REG_4094:    rd_data = regs.sr_4094;
      default:                   rd_data = spi_regs_pkg::UNMAPPED_VALUE;
    endcase
  end

  assign wr_any   = frame_done && (frame.op != spi_regs_pkg::OP_READ);
  assign wr_en[0] = wr_any && (frame.addr == spi_regs_pkg::REG_LED);
  assign wr_en[1] = wr_any && (frame.addr == spi_regs_pkg::REG_SPI_MUX);
  assign wr_en[2] = wr_any && (frame.addr == spi_regs_pkg::REG_4094);
  // unmapped address, no enable, frame dropped

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      regs.led     <= spi_regs_pkg::LED_RESET_VALUE;
      regs.spi_mux <= '0; // no downstream device selected
      regs.sr_4094 <= '0;
    end
    else
    begin
      if (wr_en[0])
        regs.led <= apply_op(regs.led, frame.op, frame.data);
      if (wr_en[1])
        regs.spi_mux <= apply_op(regs.spi_mux, frame.op, frame.data);
      if (wr_en[2])
        regs.sr_4094 <= apply_op(regs.sr_4094, frame.op, frame.data);
    end
  end

  a_one_target : assert property (@(posedge cs) disable iff (rst)
    $onehot0(wr_en));
endmodule

// ==== logic/spi_reg_top.sv ====
module spi_reg_top (
  input  logic                    cs,
  input  logic                    rst,
  input  logic                    sclk,
  input  logic                    ss_n,
  input  logic                    mosi,
  output logic                    miso,
  output spi_regs_pkg::reg_file_t regs
);

  logic                               mosi_s;
  logic                               ss_active;
  logic                               sclk_rise;
  logic                               sclk_fall;
  logic                               ss_fall;
  logic                               ss_rise;
  logic [spi_regs_pkg::ADDR_BITS-1:0] rd_addr;
  logic [spi_regs_pkg::DATA_BITS-1:0] rd_data;
  logic                               addr_strobe;
  logic                               frame_done;
  spi_regs_pkg::spi_frame_t           frame;

  // spi pins into the system clock domain
  pin_sync u_pin_sync (
    .cs        (cs),
    .rst       (rst),
    .sclk      (sclk),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .mosi_s    (mosi_s),
    .ss_active (ss_active),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .ss_fall   (ss_fall),
    .ss_rise   (ss_rise)
  );

  spi_frame_shifter u_shifter (
    .cs          (cs),
    .rst         (rst),
    .mosi_s      (mosi_s),
    .ss_active   (ss_active),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .ss_fall     (ss_fall),
    .ss_rise     (ss_rise),
    .rd_data     (rd_data),
    .miso        (miso),
    .rd_addr     (rd_addr),
    .addr_strobe (addr_strobe),
    .frame       (frame),
    .frame_done  (frame_done)
  );

  reg_bank u_reg_bank (
    .cs         (cs),
    .rst        (rst),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_done (frame_done),
    .frame      (frame),
    .regs       (regs)
  );
endmodule

// ==== testbench/tb_spi_reg_top.sv ====
module tb_spi_reg_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DIRECTED_FRAMES = 21;
  localparam int RANDOM_FRAMES   = 150;
  localparam int TIMEOUT_CYCLES  = (DIRECTED_FRAMES + RANDOM_FRAMES) * 300 + 1000;

  // one observation after a frame, expected and actual use the same shape
  typedef struct packed {
    logic                    rb_valid; // readback only meaningful for 32+ bit frames
    logic [7:0]              cmd_miso; // miso seen during the command byte
    logic [23:0]             rb;
    spi_regs_pkg::reg_file_t regs;
  } result_t;

  logic                    cs;
  logic                    rst;
  logic                    sclk;
  logic                    ss_n;
  logic                    mosi;
  logic                    miso;
  spi_regs_pkg::reg_file_t regs;

  spi_regs_pkg::reg_file_t model_regs; // shadow of the bank
  result_t                 exp_q[$];
  result_t                 got_q[$];
  logic [31:0]             rng;
  int                      cycle_count;
  int                      fail_count;

  spi_reg_top dut (
    .cs   (cs),
    .rst  (rst),
    .sclk (sclk),
    .ss_n (ss_n),
    .mosi (mosi),
    .miso (miso),
    .regs (regs)
  );

  always #20 cs = ~cs; // 40 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected readback, unknown addresses answer with the magic value
  function automatic logic [23:0] model_read(input spi_regs_pkg::reg_file_t rf,
                                             input logic [5:0] addr);
    case (addr)
      6'd7:    return rf.led;
      6'd8:    return rf.spi_mux;
      6'd9:    return rf.sr_4094;
      default: return 24'd12345;
    endcase
  endfunction

  // bank contents after a complete frame
  function automatic spi_regs_pkg::reg_file_t model_apply(
    input spi_regs_pkg::reg_file_t rf,
    input spi_regs_pkg::spi_op_e   op,
    input logic [5:0]              addr,
    input logic [23:0]             data
  );
    spi_regs_pkg::reg_file_t nx;
    logic [23:0]             upd;
    nx  = rf;
    upd = model_read(rf, addr);
    case (op)
      spi_regs_pkg::OP_WRITE: upd = data;
      spi_regs_pkg::OP_SET:   upd = upd | data;
      spi_regs_pkg::OP_CLEAR: upd = upd & ~data;
      default:                ; // read changes nothing
    endcase
    case (addr)
      6'd7:    nx.led     = upd;
      6'd8:    nx.spi_mux = upd;
      6'd9:    nx.sr_4094 = upd;
      default: ; // writes off the map are dropped
    endcase
    return nx;
  endfunction

  task automatic check(input string name, input logic [71:0] exp, input logic [71:0] got);
    if (exp !== got)
    begin
      fail_count++;
      $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, got);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value check on %s failed", name);
    end
  endtask

  // drives land 2 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #2;
  endtask

  // mode 0 master, bits[nbits-1] goes out first
  task automatic spi_xfer(input logic [63:0] bits, input int nbits,
                          output logic [23:0] rb, output logic [7:0] cmd_miso);
    rb       = '0;
    cmd_miso = '0;
    ss_n     = 1'b0;
    wait_cycles(4);
    for (int pos = 0; pos < nbits; pos++)
    begin
      mosi = bits[nbits-1-pos]; // set up while sclk low
      wait_cycles(4);
      if (pos < 8)
        cmd_miso[7-pos] = miso; // sampled just before the rise
      else if (pos < 32)
        rb[31-pos] = miso;
      sclk = 1'b1;
      wait_cycles(4);
      sclk = 1'b0;
    end
    wait_cycles(4);
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(8); // update lands 4 cycles after ss_n rises
  endtask

  task automatic send_frame(input spi_regs_pkg::spi_op_e op, input logic [5:0] addr,
                            input logic [23:0] data);
    result_t     e;
    result_t     g;
    logic [23:0] rb;
    logic [7:0]  cm;
    e.rb_valid = 1'b1;
    e.cmd_miso = 8'h00;
    e.rb       = model_read(model_regs, addr); // value before the update
    model_regs = model_apply(model_regs, op, addr, data);
    e.regs     = model_regs;
    spi_xfer({32'd0, op, addr, data}, 32, rb, cm);
    g.rb_valid = 1'b1;
    g.cmd_miso = cm;
    g.rb       = rb;
    g.regs     = regs;
    exp_q.push_back(e);
    got_q.push_back(g);
  endtask

  // short or long frame, registers must not move
  task automatic send_odd_frame(input logic [31:0] w, input int nbits);
    result_t     e;
    result_t     g;
    logic [63:0] bits;
    logic [23:0] rb;
    logic [7:0]  cm;
    // last 32 bits on the wire still form the full write of w
    bits = 64'(w);
    spi_xfer(bits, nbits, rb, cm);
    e = '{rb_valid: 1'b0, cmd_miso: 8'h00, rb: 24'h0, regs: model_regs};
    g = '{rb_valid: 1'b0, cmd_miso: cm, rb: 24'h0, regs: regs};
    exp_q.push_back(e);
    got_q.push_back(g);
  endtask

  task automatic snapshot_regs();
    result_t e;
    result_t g;
    e = '{rb_valid: 1'b0, cmd_miso: 8'h00, rb: 24'h0, regs: model_regs};
    g = '{rb_valid: 1'b0, cmd_miso: 8'h00, rb: 24'h0, regs: regs};
    exp_q.push_back(e);
    got_q.push_back(g);
  endtask

  function automatic logic [5:0] pick_addr(input logic [1:0] sel);
    case (sel)
      2'd0:    return spi_regs_pkg::REG_LED;
      2'd1:    return spi_regs_pkg::REG_SPI_MUX;
      2'd2:    return spi_regs_pkg::REG_4094;
      default: return 6'd20; // off the map
    endcase
  endfunction

  // comparison runs on the clock, sequencer only queues observations
  always @(posedge cs)
  begin
    result_t e;
    result_t g;
    if (got_q.size() > 0)
    begin
      e = exp_q.pop_front();
      g = got_q.pop_front();
      check("regs.led", 72'(e.regs.led), 72'(g.regs.led));
      check("regs.spi_mux", 72'(e.regs.spi_mux), 72'(g.regs.spi_mux));
      check("regs.sr_4094", 72'(e.regs.sr_4094), 72'(g.regs.sr_4094));
      check("miso command byte", 72'(e.cmd_miso), 72'(g.cmd_miso));
      if (e.rb_valid)
        check("miso readback", 72'(e.rb), 72'(g.rb));
    end
  end

  always @(posedge cs)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("simulation timed out after %0d cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  initial
  begin
    logic [5:0] addr;
    cs          = 1'b0;
    rst         = 1'b1;
    sclk        = 1'b0;
    ss_n        = 1'b1;
    mosi        = 1'b0;
    rng         = 32'he169_028e;
    cycle_count = 0;
    fail_count  = 0;
    model_regs  = '{led: 24'hAA_AAAA, spi_mux: 24'h0, sr_4094: 24'h0};
    wait_cycles(8);
    rst = 1'b0;
    wait_cycles(2);

    snapshot_regs(); // reset values
    for (int i = 0; i < 3; i++)
      send_frame(spi_regs_pkg::OP_READ, pick_addr(2'(i)), 24'h0);

    for (int i = 0; i < 3; i++)
    begin
      rng = xorshift32(rng);
      send_frame(spi_regs_pkg::OP_WRITE, pick_addr(2'(i)), rng[23:0]);
      send_frame(spi_regs_pkg::OP_READ, pick_addr(2'(i)), 24'h0); // reads back the write
    end

    for (int i = 0; i < 3; i++)
    begin
      send_frame(spi_regs_pkg::OP_SET, pick_addr(2'(i)), 24'h0F_F00F);
      send_frame(spi_regs_pkg::OP_CLEAR, pick_addr(2'(i)), 24'h33_3C3C);
    end

    // unmapped addresses
    send_frame(spi_regs_pkg::OP_READ, 6'd20, 24'h0);
    send_frame(spi_regs_pkg::OP_WRITE, 6'd20, 24'h55_5555);
    send_frame(spi_regs_pkg::OP_SET, 6'd63, 24'hFF_FFFF);

    send_odd_frame({spi_regs_pkg::OP_WRITE, spi_regs_pkg::REG_LED, 24'h12_3456}, 31);
    send_odd_frame({spi_regs_pkg::OP_WRITE, spi_regs_pkg::REG_LED, 24'h12_3456}, 33);
    send_frame(spi_regs_pkg::OP_READ, spi_regs_pkg::REG_LED, 24'h0);

    for (int i = 0; i < RANDOM_FRAMES; i++)
    begin
      rng  = xorshift32(rng);
      addr = pick_addr(rng[3:2]);
      send_frame(spi_regs_pkg::spi_op_e'(rng[1:0]), addr,
                 24'(xorshift32(rng ^ 32'h5a5a_0f0f)));
    end

    while (got_q.size() != 0)
      wait_cycles(1); // let the compare process drain
    wait_cycles(2);
    if (fail_count == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "%0d checks failed", fail_count);
    end
  end
endmodule

// ==== build.f ====
common/spi_regs_pkg.sv
logic/pin_sync.sv
spi_slave/spi_frame_shifter.sv
spi_slave/reg_bank.sv
logic/spi_reg_top.sv
testbench/tb_spi_reg_top.sv

// ==== Makefile ====
# Verilator flow for the SPI register block
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_spi_reg_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
SIMFLAGS  ?=

.PHONY: all lint sim clean

all: sim

# static checks on RTL and testbench together
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run; a $$fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(OBJ_DIR)
